// File: source/hsi_defs.svh
// HSI vector unit parameters
`ifndef HSI_DEFS_SVH
`define HSI_DEFS_SVH

// Width of one signed H, S or I component
`define HSI_COMPONENT_W 16

// Components per vector, also the number of product lanes
`define HSI_LANES 3

// One packed vector word, component 0 in the low bits
`define HSI_VEC_W (`HSI_LANES * `HSI_COMPONENT_W)

// Entries per FIFO, kept a power of two so the pointers wrap on their own
`define HSI_FIFO_DEPTH 16

// Fill level width, wide enough to hold the full depth
`define HSI_LEVEL_W 5

`endif

// File: source/hsi_pkg.sv
// HSI vector unit types
`include "hsi_defs.svh"

package hsi_pkg;

    typedef enum logic [3:0] {
        OP_CROSS = 4'd1,                                  // Three-band cross product
        OP_DOT   = 4'd2                                   // Dot product over 1 to 3 bands
    } hsi_op_e;

    typedef enum logic [3:0] {
        ERR_NONE  = 4'd0,                                 // Last start was accepted
        ERR_OP    = 4'd1,                                 // Op code unknown or wrong for band count
        ERR_BANDS = 4'd4                                  // Band count zero or above lane count
    } hsi_err_e;

    // Operands of one lane, result is a1*b1 - a2*b2
    typedef struct packed {
        logic signed [`HSI_COMPONENT_W-1:0] a1;
        logic signed [`HSI_COMPONENT_W-1:0] b1;
        logic signed [`HSI_COMPONENT_W-1:0] a2;
        logic signed [`HSI_COMPONENT_W-1:0] b2;
    } lane_ops_t;

    typedef struct packed {
        logic                          valid;             // One pair on the bus
        hsi_op_e                       op;                // Op latched at start
        lane_ops_t [`HSI_LANES-1:0]    lanes;             // Lane k at index k
    } issue_bus_t;

    typedef struct packed {
        logic                          valid;             // Product ready this cycle
        logic signed [`HSI_COMPONENT_W-1:0] prod;         // Truncated difference of products
    } lane_prod_t;

    // Output word, read as a vector for cross and as a scalar for dot
    typedef union packed {
        logic [`HSI_LANES-1:0][`HSI_COMPONENT_W-1:0] vec;
        struct packed {
            logic [`HSI_VEC_W-`HSI_COMPONENT_W-1:0] pad;    // Upper components, zero
            logic signed [`HSI_COMPONENT_W-1:0]     scalar; // Dot result in component 0
        } dot;
    } result_word_u;

endpackage

// File: source/vector_fifo.sv
// Show-ahead vector FIFO
`timescale 1ns/1ps
`include "hsi_defs.svh"

module vector_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  logic [`HSI_VEC_W-1:0]   data_in,
    output logic [`HSI_VEC_W-1:0]   data_out,
    output logic                    full,
    output logic                    empty,
    output logic [`HSI_LEVEL_W-1:0] level
);

    localparam int DEPTH = `HSI_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LW    = `HSI_LEVEL_W;

    logic [`HSI_VEC_W-1:0] mem [DEPTH];                  // Storage, no reset
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [LW-1:0]         count;                        // Entries held
    logic                  do_wr;
    logic                  do_rd;

    assign full     = (count == LW'(DEPTH));
    assign empty    = (count == '0);
    assign level    = count;
    assign do_wr    = wr_en && !full;                    // Write on full is dropped
    assign do_rd    = rd_en && !empty;                   // Read on empty is dropped
    assign data_out = mem[rd_ptr];                       // Head visible without a read

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;          // Wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                 // Idle or read and write together
            endcase
        end
    end

    // Count matches the pointer distance modulo the depth
    a_count_ptrs: assert property (
        @(posedge clk) disable iff (!rst_n)
            count[PTR_W-1:0] == PTR_W'(wr_ptr - rd_ptr)
    );

endmodule

// File: source/pair_issue.sv
// Pair issue stage
`timescale 1ns/1ps
`include "hsi_defs.svh"

module pair_issue import hsi_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  hsi_op_e                 op_code,
    input  logic [31:0]             num_bands,
    input  logic [`HSI_VEC_W-1:0]   in1_data,
    input  logic [`HSI_VEC_W-1:0]   in2_data,
    input  logic                    in1_empty,
    input  logic                    in2_empty,
    input  logic [`HSI_LEVEL_W-1:0] out_level,
    input  logic                    result_written,
    output logic                    in1_pop,
    output logic                    in2_pop,
    output issue_bus_t              issue,
    output logic                    busy,
    output hsi_err_e                error_code
);

    localparam int W             = `HSI_COMPONENT_W;
    localparam int N             = `HSI_LANES;
    localparam int LW            = `HSI_LEVEL_W;
    localparam int MAX_IN_FLIGHT = 3;                    // Issue, lane and pack registers

    hsi_op_e           op_q;                             // Op of the current run
    logic [1:0]        bands_q;                          // Active lanes, 1 to 3
    logic [LW-1:0]     in_flight;                        // Popped but not yet in out FIFO
    logic [LW:0]       credit_sum;
    logic              pop;
    hsi_err_e          start_err;
    lane_ops_t [N-1:0] lanes_next;
    logic              issue_valid_q;
    hsi_op_e           issue_op_q;
    lane_ops_t [N-1:0] issue_lanes_q;

    // Band check wins over the op check
    always_comb begin
        if (num_bands == 32'd0 || num_bands > 32'(N)) begin
            start_err = ERR_BANDS;
        end else if (op_code == OP_DOT || (op_code == OP_CROSS && num_bands == 32'd3)) begin
            start_err = ERR_NONE;
        end else begin
            start_err = ERR_OP;
        end
    end

    assign credit_sum = {1'b0, out_level} + {1'b0, in_flight};
    assign pop        = busy && !in1_empty && !in2_empty   // Output slot reserved per pair
                        && (credit_sum < (LW + 1)'(`HSI_FIFO_DEPTH));
    assign in1_pop    = pop;
    assign in2_pop    = pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            error_code <= ERR_NONE;
            op_q       <= OP_CROSS;
            bands_q    <= 2'd0;
        end else if (busy) begin
            if ((in1_empty || in2_empty) && in_flight == '0) busy <= 1'b0;  // Inputs drained
        end else if (start) begin
            error_code <= start_err;                     // Held until next start
            if (start_err == ERR_NONE) begin
                busy    <= 1'b1;
                op_q    <= op_code;
                bands_q <= num_bands[1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            case ({pop, result_written})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;         // Both or neither cancel out
            endcase
        end
    end

    // Operand routing, idle lanes see zeros
    always_comb begin
        lanes_next = '0;
        for (int k = 0; k < N; k++) begin
            if (k < int'(bands_q)) begin
                if (op_q == OP_CROSS) begin
                    lanes_next[k].a1 = in1_data[((k + 1) % N) * W +: W];  // v[k+1]
                    lanes_next[k].b1 = in2_data[((k + 2) % N) * W +: W];  // w[k+2]
                    lanes_next[k].a2 = in1_data[((k + 2) % N) * W +: W];  // v[k+2]
                    lanes_next[k].b2 = in2_data[((k + 1) % N) * W +: W];  // w[k+1]
                end else begin
                    lanes_next[k].a1 = in1_data[k * W +: W];              // Plain v[k]*w[k]
                    lanes_next[k].b1 = in2_data[k * W +: W];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) issue_valid_q <= 1'b0;
        else        issue_valid_q <= pop;                // Bus valid the cycle after the pop
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_op_q    <= op_q;
            issue_lanes_q <= lanes_next;                 // Heads sampled at the pop
        end
    end

    assign issue.valid = issue_valid_q;
    assign issue.op    = issue_op_q;
    assign issue.lanes = issue_lanes_q;

    // Every packer write belongs to a pair counted at its pop
    a_write_counted: assert property (
        @(posedge clk) disable iff (!rst_n) result_written |-> in_flight != '0
    );

    // Write strobes from the packer keep the counter within pipeline depth
    a_in_flight_max: assert property (
        @(posedge clk) disable iff (!rst_n) in_flight <= LW'(MAX_IN_FLIGHT)
    );

endmodule

// File: source/product_lane.sv
// Signed product lane
`timescale 1ns/1ps
`include "hsi_defs.svh"

module product_lane import hsi_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  lane_ops_t  ops,
    input  logic       ops_valid,
    output lane_prod_t prod
);

    localparam int W = `HSI_COMPONENT_W;

    logic signed [2*W-1:0] mul_1;                        // a1*b1, full width
    logic signed [2*W-1:0] mul_2;                        // a2*b2
    logic signed [2*W-1:0] diff;
    logic                  valid_q;
    logic signed [W-1:0]   prod_q;

    assign mul_1 = $signed(ops.a1) * $signed(ops.b1);
    assign mul_2 = $signed(ops.a2) * $signed(ops.b2);
    assign diff  = mul_1 - mul_2;                        // Zero a2/b2 gives a plain product

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) valid_q <= 1'b0;
        else        valid_q <= ops_valid;
    end

    always_ff @(posedge clk) begin
        prod_q <= diff[W-1:0];                           // Truncated to one component
    end

    assign prod.valid = valid_q;
    assign prod.prod  = prod_q;

endmodule

// File: source/result_pack.sv
// Result packer
`timescale 1ns/1ps
`include "hsi_defs.svh"

module result_pack import hsi_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  hsi_op_e                     op,
    input  lane_prod_t [`HSI_LANES-1:0] prods,
    output logic                        out_wr,
    output result_word_u                out_data
);

    localparam int W = `HSI_COMPONENT_W;
    localparam int N = `HSI_LANES;

    hsi_op_e             op_q;                           // Op aligned with lane outputs
    logic [N-1:0]        lane_valid;
    logic signed [W-1:0] dot_sum;
    result_word_u        word_next;

    always_ff @(posedge clk) begin
        op_q <= op;                                      // Lanes add one cycle
    end

    always_comb begin
        for (int k = 0; k < N; k++) begin
            lane_valid[k] = prods[k].valid;
        end
    end

    // Idle lanes hold zero, so summing all of them is safe
    always_comb begin
        dot_sum = '0;
        for (int k = 0; k < N; k++) begin
            dot_sum = dot_sum + prods[k].prod;           // Wraps at component width
        end
    end

    always_comb begin
        word_next = '0;
        if (op_q == OP_CROSS) begin
            for (int k = 0; k < N; k++) begin
                word_next.vec[k] = prods[k].prod;        // Lane k to component k
            end
        end else begin
            word_next.dot.pad    = '0;
            word_next.dot.scalar = dot_sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) out_wr <= 1'b0;
        else        out_wr <= lane_valid[0];             // All lanes move in step
    end

    always_ff @(posedge clk) begin
        if (lane_valid[0]) begin
            out_data <= word_next;
        end
    end

    // A write comes from a cycle where every lane held a product
    a_lanes_in_step: assert property (
        @(posedge clk) disable iff (!rst_n) out_wr |-> $past(&lane_valid)
    );

    // No lane runs ahead of the others
    a_no_partial: assert property (
        @(posedge clk) disable iff (!rst_n) (|lane_valid) |-> (&lane_valid)
    );

endmodule

// File: source/hsi_vector_core.sv
// HSI vector core top
`timescale 1ns/1ps
`include "hsi_defs.svh"

module hsi_vector_core import hsi_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in1_wr_en,
    input  logic [`HSI_VEC_W-1:0] in1_data,
    input  logic                  in2_wr_en,
    input  logic [`HSI_VEC_W-1:0] in2_data,
    input  logic                  out_rd_en,
    input  logic                  start,
    input  logic [3:0]            op_code,
    input  logic [31:0]           num_bands,
    output logic                  in1_full,
    output logic                  in2_full,
    output result_word_u          out_data,
    output logic                  out_empty,
    output logic                  out_full,
    output logic                  busy,
    output hsi_err_e              error_code
);

    logic                          in1_pop;
    logic                          in2_pop;
    logic [`HSI_VEC_W-1:0]         in1_head;             // Show-ahead heads
    logic [`HSI_VEC_W-1:0]         in2_head;
    logic                          in1_empty;
    logic                          in2_empty;
    logic [`HSI_LEVEL_W-1:0]       out_level;            // Used for issue credit
    issue_bus_t                    issue;
    lane_prod_t [`HSI_LANES-1:0]   prods;
    logic                          out_wr;
    result_word_u                  pack_data;

    vector_fifo u_in1_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (in1_wr_en),
        .rd_en    (in1_pop),
        .data_in  (in1_data),
        .data_out (in1_head),
        .full     (in1_full),
        .empty    (in1_empty),
        .level    ()                                     // Input levels not needed
    );

    vector_fifo u_in2_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (in2_wr_en),
        .rd_en    (in2_pop),
        .data_in  (in2_data),
        .data_out (in2_head),
        .full     (in2_full),
        .empty    (in2_empty),
        .level    ()
    );

    pair_issue u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .op_code        (hsi_op_e'(op_code)),            // Unknown codes reach the check as is
        .num_bands      (num_bands),
        .in1_data       (in1_head),
        .in2_data       (in2_head),
        .in1_empty      (in1_empty),
        .in2_empty      (in2_empty),
        .out_level      (out_level),
        .result_written (out_wr),
        .in1_pop        (in1_pop),
        .in2_pop        (in2_pop),
        .issue          (issue),
        .busy           (busy),
        .error_code     (error_code)
    );

    for (genvar k = 0; k < `HSI_LANES; k++) begin : g_lane
        product_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .ops       (issue.lanes[k]),
            .ops_valid (issue.valid),                    // Shared valid keeps lanes in step
            .prod      (prods[k])
        );
    end

    result_pack u_pack (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (issue.op),
        .prods    (prods),
        .out_wr   (out_wr),
        .out_data (pack_data)
    );

    vector_fifo u_out_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (out_wr),
        .rd_en    (out_rd_en),
        .data_in  (pack_data),
        .data_out (out_data),
        .full     (out_full),
        .empty    (out_empty),
        .level    (out_level)
    );

endmodule

// File: tests/hsi_vector_core_tb.sv
// HSI vector core testbench
`timescale 1ns/1ps
`include "hsi_defs.svh"

module hsi_vector_core_tb
    import hsi_pkg::*;
();

    localparam int W         = `HSI_COMPONENT_W;
    localparam int N         = `HSI_LANES;
    localparam int VW        = `HSI_VEC_W;
    localparam int DOT_PAIRS = 6;                        // Per band count
    localparam int PAIRS     = 8 + 3 * DOT_PAIRS + 2 + 16 + 16;
    localparam int TIMEOUT   = PAIRS * 20 + 300;         // Cycles, margin for reset and gaps

    logic          clk;
    logic          rst_n;
    logic          in1_wr_en;
    logic [VW-1:0] in1_data;
    logic          in2_wr_en;
    logic [VW-1:0] in2_data;
    logic          out_rd_en;
    logic          start;
    logic [3:0]    op_code;
    logic [31:0]   num_bands;
    logic          in1_full;
    logic          in2_full;
    result_word_u  out_data;
    logic          out_empty;
    logic          out_full;
    logic          busy;
    hsi_err_e      error_code;

    logic [VW-1:0] exp_words [$];                        // Expected results in order
    logic [3:0]    exp_ops [$];                          // Op behind each result
    logic          drain_on;                             // Host reads the output FIFO
    int            errors;
    int            checks;
    int            received;
    int            tests_run;

    hsi_vector_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                          // 100 ns period
    end

    // Expected word from the cross and dot rules
    function automatic logic [VW-1:0] hsi_ref(input logic [3:0] op, input int bands,
                                              input logic [VW-1:0] v, input logic [VW-1:0] w);
        logic signed [W-1:0]   vc [N];
        logic signed [W-1:0]   wc [N];
        logic signed [2*W-1:0] term;
        logic [W-1:0]          acc;
        logic [VW-1:0]         res;
        int                    k;
        res = '0;
        acc = '0;
        for (k = 0; k < N; k++) begin
            vc[k] = v[k*W +: W];
            wc[k] = w[k*W +: W];
        end
        if (op == OP_CROSS) begin
            for (k = 0; k < N; k++) begin
                term = vc[(k+1)%N] * wc[(k+2)%N] - vc[(k+2)%N] * wc[(k+1)%N];
                res[k*W +: W] = term[W-1:0];             // Component k, wrapped
            end
        end else begin
            for (k = 0; k < bands; k++) begin
                term = vc[k] * wc[k];
                acc  = acc + term[W-1:0];                // Wraps like the hardware
            end
            res[W-1:0] = acc;                            // Upper components stay zero
        end
        return res;
    endfunction

    function automatic logic [VW-1:0] rand_vec();
        return VW'({$urandom(), $urandom()});
    endfunction

    task automatic check_equal(input string name, input logic [VW-1:0] got,
                               input logic [VW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_vecs(input logic e1, input logic e2,
                              input logic [VW-1:0] v, input logic [VW-1:0] w);
        @(posedge clk);
        in1_wr_en <= e1;
        in2_wr_en <= e2;
        in1_data  <= v;
        in2_data  <= w;
    endtask

    task automatic expect_result(input logic [3:0] op, input int bands,
                                 input logic [VW-1:0] v, input logic [VW-1:0] w);
        exp_words.push_back(hsi_ref(op, bands, v, w));
        exp_ops.push_back(op);
    endtask

    task automatic load_pair(input logic [3:0] op, input int bands,
                             input logic [VW-1:0] v, input logic [VW-1:0] w);
        write_vecs(1'b1, 1'b1, v, w);
        expect_result(op, bands, v, w);
    endtask

    task automatic start_run(input logic [3:0] op, input logic [31:0] bands);
        @(posedge clk);
        start     <= 1'b1;
        op_code   <= op;
        num_bands <= bands;
        @(posedge clk);
        start     <= 1'b0;                               // One-cycle pulse
        @(negedge clk);                                  // error_code and busy settled here
    endtask

    // Done once busy is low and every expected result has come back
    task automatic wait_done(input int pairs);
        int   cycles;
        logic idle;
        cycles = 0;
        idle   = 1'b0;
        while (!(idle && exp_words.size() == 0) && cycles < pairs * 20 + 50) begin
            @(negedge clk);
            idle = !busy;
            @(posedge clk);                              // Queue only changes at negedge
            cycles++;
        end
        if (!(idle && exp_words.size() == 0)) begin
            errors++;
            $display("Run of %0d pairs did not finish by %0t ns", pairs, $time);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("Test %s done with %0d errors", name, errors - errs_before);
    endtask

    initial begin : main_flow
        int            seed;
        int            errs;
        int            rec_before;
        int            cycles;
        int            b;
        int            i;
        logic [VW-1:0] v;
        logic [VW-1:0] w;
        logic [VW-1:0] held [16];
        rst_n     = 1'b0;
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
        in1_data  = '0;
        in2_data  = '0;
        out_rd_en = 1'b0;
        start     = 1'b0;
        op_code   = 4'd0;
        num_bands = 32'd0;
        drain_on  = 1'b1;
        errors    = 0;
        checks    = 0;
        received  = 0;
        tests_run = 0;
        seed      = $urandom(41);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        errs = errors;                                   // Cross product run
        for (i = 0; i < 8; i++) begin
            v = rand_vec();
            w = rand_vec();
            load_pair(OP_CROSS, 3, v, w);
        end
        write_vecs(1'b0, 1'b0, '0, '0);
        start_run(OP_CROSS, 3);
        check_equal("error_code", error_code, ERR_NONE);
        wait_done(8);
        @(negedge clk);
        check_equal("busy", busy, 1'b0);
        report_test("cross_product", errs);

        errs = errors;                                   // Dot product over 1 to 3 bands
        for (b = 1; b <= 3; b++) begin
            for (i = 0; i < DOT_PAIRS; i++) begin
                v = rand_vec();
                w = rand_vec();
                if (i == 0) begin
                    v = {N{16'h8000}};                   // Most negative squared wraps to 0
                    w = {N{16'h8000}};
                end else if (i == 1) begin
                    v = {N{16'h7fff}};
                    w = {N{16'h8000}};
                end
                load_pair(OP_DOT, b, v, w);
            end
            write_vecs(1'b0, 1'b0, '0, '0);
            start_run(OP_DOT, b);
            wait_done(DOT_PAIRS);
        end
        report_test("dot_product", errs);

        errs = errors;                                   // Bad starts leave loaded pairs alone
        for (i = 0; i < 2; i++) begin
            load_pair(OP_DOT, 2, rand_vec(), rand_vec());
        end
        write_vecs(1'b0, 1'b0, '0, '0);
        start_run(OP_CROSS, 2);
        check_equal("error_code", error_code, ERR_OP);
        check_equal("busy", busy, 1'b0);
        start_run(OP_DOT, 0);
        check_equal("error_code", error_code, ERR_BANDS);
        check_equal("busy", busy, 1'b0);
        start_run(4'd5, 3);
        check_equal("error_code", error_code, ERR_OP);
        repeat (4) @(negedge clk);
        check_equal("busy", busy, 1'b0);
        check_equal("out_empty", out_empty, 1'b1);
        start_run(OP_DOT, 2);
        check_equal("error_code", error_code, ERR_NONE);
        wait_done(2);
        report_test("config_errors", errs);

        errs       = errors;                             // Output back-pressure
        rec_before = received;
        drain_on   = 1'b0;
        for (i = 0; i < 16; i++) begin
            load_pair(OP_CROSS, 3, rand_vec(), rand_vec());
        end
        write_vecs(1'b0, 1'b0, '0, '0);
        start_run(OP_CROSS, 3);
        cycles = 0;
        while ((!out_full || busy) && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        check_equal("out_full", out_full, 1'b1);
        check_equal("busy", busy, 1'b0);
        check_equal("results before drain", received - rec_before, 0);
        @(posedge clk);
        drain_on = 1'b1;
        wait_done(16);
        check_equal("results received", received - rec_before, 16);
        report_test("back_pressure", errs);

        errs       = errors;                             // Input FIFO full, 17th write dropped
        rec_before = received;
        for (i = 0; i < 16; i++) begin
            held[i] = rand_vec();
            write_vecs(1'b1, 1'b0, held[i], '0);
        end
        write_vecs(1'b0, 1'b0, '0, '0);
        @(negedge clk);
        check_equal("in1_full", in1_full, 1'b1);
        check_equal("in2_full", in2_full, 1'b0);         // Second input still empty
        write_vecs(1'b1, 1'b0, rand_vec(), '0);
        write_vecs(1'b0, 1'b0, '0, '0);
        @(negedge clk);
        check_equal("in1_full", in1_full, 1'b1);
        for (i = 0; i < 16; i++) begin
            w = rand_vec();
            write_vecs(1'b0, 1'b1, '0, w);
            expect_result(OP_CROSS, 3, held[i], w);
        end
        write_vecs(1'b0, 1'b0, '0, '0);
        @(negedge clk);
        check_equal("in2_full", in2_full, 1'b1);
        start_run(OP_CROSS, 3);
        wait_done(16);
        repeat (10) @(negedge clk);
        check_equal("results received", received - rec_before, 16);
        check_equal("out_empty", out_empty, 1'b1);
        check_equal("pending results", exp_words.size(), 0);
        report_test("input_full", errs);

        $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Reads one word every other cycle, head sampled at negedge
    initial begin : compare_outputs
        logic [VW-1:0] exp_word;
        logic [3:0]    exp_op;
        forever begin
            @(negedge clk);
            if (rst_n && drain_on && !out_empty) begin
                if (exp_words.size() == 0) begin
                    errors++;
                    $display("Output word %h appeared at %0t ns with no result expected",
                             out_data, $time);
                end else begin
                    exp_word = exp_words.pop_front();
                    exp_op   = exp_ops.pop_front();
                    if (exp_op == OP_DOT) begin          // Decode by the requested op
                        check_equal("out_data.dot.scalar", {32'd0, out_data.dot.scalar},
                                    {32'd0, exp_word[W-1:0]});
                        check_equal("out_data.dot.pad", {16'd0, out_data.dot.pad},
                                    {16'd0, exp_word[VW-1:W]});
                    end else begin
                        check_equal("out_data.vec", out_data.vec, exp_word);
                    end
                end
                received++;
                @(posedge clk);
                out_rd_en <= 1'b1;
                @(posedge clk);
                out_rd_en <= 1'b0;                       // Read taken at this edge
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT);
        $display("Something failed");
        $finish;
    end

endmodule

// File: hsi_vector_core.f
+incdir+source
source/hsi_pkg.sv
source/vector_fifo.sv
source/pair_issue.sv
source/product_lane.sv
source/result_pack.sv
source/hsi_vector_core.sv
tests/hsi_vector_core_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f hsi_vector_core.f \
    --top-module hsi_vector_core_tb -o hsi_sim > build.log 2>&1 \
    && ./obj_dir/hsi_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation reported a failure"; exit 1; } \
    || grep -q "Everything OK" sim.log || { echo "No pass line in the log"; exit 1; }
